// ==== common/isa_pkg.sv ====
package isa_pkg;

   // Primary opcode field, bits 31:26 of the instruction word
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_BEQ   = 6'h04,
      OP_ADDI  = 6'h08
   } opcode_t;

   // Function field of register-format instructions
   typedef enum logic [5:0] {
      FN_MULT = 6'h18,
      FN_ADD  = 6'h20,
      FN_SUB  = 6'h22,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_SLT  = 6'h2a
   } funct_t;

   // Operation carried to the integer station
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT,
      ALU_BEQ
   } alu_op_t;

   // Register format view; immediate and jump fields are slices of the same word
   typedef struct packed {
      opcode_t    opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      funct_t     funct;
   } inst_t;

endpackage

// ==== common/tomasulo_pkg.sv ====
package tomasulo_pkg;

   localparam int TAG_W = 4;

   typedef logic [TAG_W-1:0] tag_t;

   // A source operand is either a value or the tag of its producer
   typedef struct packed {
      logic [31:0] value;
      tag_t        tag;
      logic        ready;
   } operand_t;

   typedef struct packed {
      isa_pkg::alu_op_t alu_op;
      tag_t             dest;
      operand_t         rs;
      operand_t         rt;
   } issue_t;

   typedef struct packed {
      logic        valid;
      tag_t        tag;
      logic [31:0] data;
      logic        is_branch;
      logic        taken;
   } cdb_t;

   // Picks up a broadcast value for an operand still waiting on that tag
   function automatic operand_t snoop(input operand_t op, input cdb_t bus);
      operand_t res;
      res = op;
      if (!op.ready && bus.valid && bus.tag == op.tag) begin
         res.value = bus.data;
         res.ready = 1'b1;
      end
      return res;
   endfunction

endpackage

// ==== hw/dispatch/reg_status_file.sv ====
`timescale 1ns/1ps

module reg_status_file (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic [4:0]             rs_addr,
   input  logic [4:0]             rt_addr,
   output tomasulo_pkg::operand_t rs_operand,
   output tomasulo_pkg::operand_t rt_operand,
   input  logic                   rename_en,
   input  logic [4:0]             rename_addr,
   input  tomasulo_pkg::tag_t     rename_tag,
   input  tomasulo_pkg::cdb_t     cdb,
   input  logic [4:0]             debug_addr,
   output logic [31:0]            debug_data
);
   import tomasulo_pkg::*;

   logic [31:0] value [32];
   tag_t        tag [32];
   logic [31:0] busy;

   // Raw read; forwarding of a same-cycle broadcast happens in dispatch
   always_comb begin
      rs_operand = '{value: value[rs_addr], tag: tag[rs_addr], ready: !busy[rs_addr]};
      rt_operand = '{value: value[rt_addr], tag: tag[rt_addr], ready: !busy[rt_addr]};
   end

   assign debug_data = value[debug_addr];

   // Entry 0 is never written, so it stays ready and zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 32; i++) begin
            value[i] <= '0;
            tag[i]   <= '0;
         end
         busy <= '0;
      end else begin
         for (int i = 1; i < 32; i++) begin
            if (cdb.valid && busy[i] && tag[i] == cdb.tag) begin
               value[i] <= cdb.data;
               busy[i]  <= 1'b0;
            end
            // A new producer overrides the completing one
            if (rename_en && rename_addr == 5'(i)) begin
               busy[i] <= 1'b1;
               tag[i]  <= rename_tag;
            end
         end
      end
   end

endmodule

// ==== hw/dispatch/tag_fifo.sv ====
`timescale 1ns/1ps

module tag_fifo #(
   parameter int NUM_TAGS = 8
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               pop,
   output tomasulo_pkg::tag_t tag,
   output logic               empty,
   output logic               full,
   input  tomasulo_pkg::cdb_t cdb
);
   import tomasulo_pkg::*;

   localparam int PTR_W = $clog2(NUM_TAGS);
   localparam int CNT_W = $clog2(NUM_TAGS + 1);

   tag_t             mem [NUM_TAGS];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(NUM_TAGS - 1)) ? '0 : p + 1'b1;
   endfunction

   // Every broadcast hands its tag back, branches included
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_TAGS; i++) begin
            mem[i] <= tag_t'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= CNT_W'(NUM_TAGS);
      end else begin
         if (cdb.valid) begin
            mem[wr_ptr] <= cdb.tag;
            wr_ptr      <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + CNT_W'(cdb.valid) - CNT_W'(pop);
      end
   end

   assign tag   = mem[rd_ptr];
   assign empty = count == '0;
   assign full  = count == CNT_W'(NUM_TAGS);

endmodule

// ==== hw/dispatch/dispatch.sv ====
`timescale 1ns/1ps

module dispatch #(
   parameter int NUM_TAGS = 8
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic [31:0]          ifq_inst,
   input  logic [31:0]          ifq_pc_plus4,
   input  logic                 ifq_empty,
   output logic                 ifq_ren,
   output logic                 ifq_branch_valid,
   output logic [31:0]          ifq_branch_addr,
   output tomasulo_pkg::issue_t issue,
   output logic                 alu_issue_en,
   output logic                 mult_issue_en,
   input  logic                 alu_free,
   input  logic                 mult_free,
   input  tomasulo_pkg::cdb_t   cdb,
   input  logic [4:0]           debug_addr,
   output logic [31:0]          debug_data,
   output logic                 quiescent
);
   import isa_pkg::*;
   import tomasulo_pkg::*;

   typedef enum logic {DISPATCH, BRANCH_STALL} state_t;

   state_t      state;
   state_t      state_next;
   inst_t       inst;
   logic [31:0] imm_sext;
   logic [31:0] branch_target;
   logic [31:0] branch_target_r;
   logic [31:0] jump_target;
   logic        is_rtype;
   logic        is_addi;
   logic        is_beq;
   logic        is_j;
   logic        is_mult;
   logic        station_free;
   logic        fire;
   alu_op_t     alu_op;
   operand_t    rs_raw;
   operand_t    rt_raw;
   logic        rename_en;
   logic [4:0]  rename_addr;
   tag_t        free_tag;
   logic        tag_empty;
   logic        tag_full;

   assign inst          = inst_t'(ifq_inst);
   assign imm_sext      = {{16{ifq_inst[15]}}, ifq_inst[15:0]};
   assign branch_target = ifq_pc_plus4 + {imm_sext[29:0], 2'b00};
   assign jump_target   = ifq_pc_plus4 + {{4{ifq_inst[25]}}, ifq_inst[25:0], 2'b00};

   assign is_rtype = inst.opcode == OP_RTYPE;
   assign is_addi  = inst.opcode == OP_ADDI;
   assign is_beq   = inst.opcode == OP_BEQ;
   assign is_j     = inst.opcode == OP_J;
   assign is_mult  = is_rtype && inst.funct == FN_MULT;

   always_comb begin
      alu_op = ALU_ADD;
      if (is_beq) begin
         alu_op = ALU_BEQ;
      end else if (is_rtype) begin
         case (inst.funct)
            FN_SUB:  alu_op = ALU_SUB;
            FN_AND:  alu_op = ALU_AND;
            FN_OR:   alu_op = ALU_OR;
            FN_SLT:  alu_op = ALU_SLT;
            default: alu_op = ALU_ADD;
         endcase
      end
   end

   // Jumps never need a station or a tag; everything else needs both
   assign station_free  = is_mult ? mult_free : alu_free;
   assign fire          = state == DISPATCH && !ifq_empty &&
                          (is_j || (station_free && !tag_empty));
   assign ifq_ren       = fire;
   assign alu_issue_en  = fire && !is_j && !is_mult;
   assign mult_issue_en = fire && is_mult;

   // BEQ still takes a tag so its outcome can be broadcast and returned
   assign rename_en   = fire && !is_j && !is_beq;
   assign rename_addr = is_addi ? inst.rt : inst.rd;

   always_comb begin
      issue.alu_op = alu_op;
      issue.dest   = free_tag;
      issue.rs     = snoop(rs_raw, cdb);
      if (is_addi) begin
         issue.rt = '{value: imm_sext, tag: '0, ready: 1'b1};
      end else begin
         issue.rt = snoop(rt_raw, cdb);
      end
   end

   always_comb begin
      state_next       = state;
      ifq_branch_valid = 1'b0;
      ifq_branch_addr  = jump_target;
      case (state)
         DISPATCH: begin
            if (fire && is_j) begin
               ifq_branch_valid = 1'b1;
            end
            if (fire && is_beq) begin
               state_next = BRANCH_STALL;
            end
         end
         BRANCH_STALL: begin
            ifq_branch_addr = branch_target_r;
            // Only one branch is ever in flight, so any branch result is ours
            if (cdb.valid && cdb.is_branch) begin
               ifq_branch_valid = cdb.taken;
               state_next       = DISPATCH;
            end
         end
         default: state_next = DISPATCH;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= DISPATCH;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (fire && is_beq) begin
         branch_target_r <= branch_target;
      end
   end

   reg_status_file u_reg_status_file (
      .clk         (clk),
      .arst_n      (arst_n),
      .rs_addr     (inst.rs),
      .rt_addr     (inst.rt),
      .rs_operand  (rs_raw),
      .rt_operand  (rt_raw),
      .rename_en   (rename_en),
      .rename_addr (rename_addr),
      .rename_tag  (free_tag),
      .cdb         (cdb),
      .debug_addr  (debug_addr),
      .debug_data  (debug_data)
   );

   tag_fifo #(
      .NUM_TAGS (NUM_TAGS)
   ) u_tag_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .pop    (alu_issue_en | mult_issue_en),
      .tag    (free_tag),
      .empty  (tag_empty),
      .full   (tag_full),
      .cdb    (cdb)
   );

   // All tags home means nothing is left in flight
   assign quiescent = tag_full;

endmodule

// ==== hw/alu_station.sv ====
`timescale 1ns/1ps

module alu_station (
   input  logic                 clk,
   input  logic                 arst_n,
   input  tomasulo_pkg::issue_t issue,
   input  logic                 issue_en,
   output logic                 free,
   input  tomasulo_pkg::cdb_t   cdb,
   output logic                 req,
   input  logic                 gnt,
   output tomasulo_pkg::cdb_t   result
);
   import isa_pkg::*;
   import tomasulo_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_REQ} state_t;

   state_t      state;
   issue_t      entry;
   logic [31:0] alu_out;

   always_comb begin
      case (entry.alu_op)
         ALU_ADD: alu_out = entry.rs.value + entry.rt.value;
         ALU_SUB: alu_out = entry.rs.value - entry.rt.value;
         ALU_AND: alu_out = entry.rs.value & entry.rt.value;
         ALU_OR:  alu_out = entry.rs.value | entry.rt.value;
         ALU_SLT: alu_out = ($signed(entry.rs.value) < $signed(entry.rt.value)) ? 32'd1 : 32'd0;
         default: alu_out = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (issue_en) state <= ST_WAIT;
            ST_WAIT: if (entry.rs.ready && entry.rt.ready) state <= ST_REQ;
            ST_REQ:  if (gnt) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (issue_en) begin
         entry <= issue;
      end else if (state == ST_WAIT) begin
         entry.rs <= snoop(entry.rs, cdb);
         entry.rt <= snoop(entry.rt, cdb);
      end
   end

   assign free = state == ST_IDLE;
   assign req  = state == ST_REQ;

   // The entry is frozen while requesting, so the candidate holds until granted
   always_comb begin
      result.valid     = req;
      result.tag       = entry.dest;
      result.data      = alu_out;
      result.is_branch = entry.alu_op == ALU_BEQ;
      result.taken     = entry.alu_op == ALU_BEQ && entry.rs.value == entry.rt.value;
   end

endmodule

// ==== hw/mult_station.sv ====
`timescale 1ns/1ps

module mult_station (
   input  logic                 clk,
   input  logic                 arst_n,
   input  tomasulo_pkg::issue_t issue,
   input  logic                 issue_en,
   output logic                 free,
   input  tomasulo_pkg::cdb_t   cdb,
   output logic                 req,
   input  logic                 gnt,
   output tomasulo_pkg::cdb_t   result
);
   import tomasulo_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_PIPE, ST_REQ} state_t;

   state_t      state;
   issue_t      entry;
   logic [31:0] prod_s1;
   logic [31:0] prod_s2;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (issue_en) state <= ST_WAIT;
            ST_WAIT: if (entry.rs.ready && entry.rt.ready) state <= ST_PIPE;
            ST_PIPE: state <= ST_REQ;
            ST_REQ:  if (gnt) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Low half of the product only, split over two register stages
   always_ff @(posedge clk) begin
      if (issue_en) begin
         entry <= issue;
      end else if (state == ST_WAIT) begin
         entry.rs <= snoop(entry.rs, cdb);
         entry.rt <= snoop(entry.rt, cdb);
      end
      if (state == ST_WAIT) begin
         prod_s1 <= entry.rs.value * entry.rt.value;
      end
      if (state == ST_PIPE) begin
         prod_s2 <= prod_s1;
      end
   end

   assign free = state == ST_IDLE;
   assign req  = state == ST_REQ;

   always_comb begin
      result.valid     = req;
      result.tag       = entry.dest;
      result.data      = prod_s2;
      result.is_branch = 1'b0;
      result.taken     = 1'b0;
   end

endmodule

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               req_alu,
   input  logic               req_mult,
   output logic               gnt_alu,
   output logic               gnt_mult,
   input  tomasulo_pkg::cdb_t result_alu,
   input  tomasulo_pkg::cdb_t result_mult,
   output tomasulo_pkg::cdb_t cdb
);
   typedef enum logic {WIN_ALU, WIN_MULT} winner_t;

   winner_t last;

   // On a tie the station that did not win last time goes first
   assign gnt_alu  = req_alu && (!req_mult || last == WIN_MULT);
   assign gnt_mult = req_mult && !gnt_alu;

   always_comb begin
      if (gnt_alu) begin
         cdb = result_alu;
      end else if (gnt_mult) begin
         cdb = result_mult;
      end else begin
         cdb = '0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         last <= WIN_MULT;
      end else if (gnt_alu) begin
         last <= WIN_ALU;
      end else if (gnt_mult) begin
         last <= WIN_MULT;
      end
   end

endmodule

// ==== hw/tomasulo_core.sv ====
`timescale 1ns/1ps

module tomasulo_core #(
   parameter int NUM_TAGS = 8
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic [31:0]        ifq_inst,
   input  logic [31:0]        ifq_pc_plus4,
   input  logic               ifq_empty,
   output logic               ifq_ren,
   output logic               ifq_branch_valid,
   output logic [31:0]        ifq_branch_addr,
   input  logic [4:0]         debug_addr,
   output logic [31:0]        debug_data,
   output logic               quiescent,
   output tomasulo_pkg::cdb_t cdb
);
   import tomasulo_pkg::*;

   issue_t issue;
   logic   alu_issue_en;
   logic   mult_issue_en;
   logic   alu_free;
   logic   mult_free;
   logic   alu_req;
   logic   mult_req;
   logic   alu_gnt;
   logic   mult_gnt;
   cdb_t   alu_result;
   cdb_t   mult_result;

   dispatch #(
      .NUM_TAGS (NUM_TAGS)
   ) u_dispatch (
      .clk              (clk),
      .arst_n           (arst_n),
      .ifq_inst         (ifq_inst),
      .ifq_pc_plus4     (ifq_pc_plus4),
      .ifq_empty        (ifq_empty),
      .ifq_ren          (ifq_ren),
      .ifq_branch_valid (ifq_branch_valid),
      .ifq_branch_addr  (ifq_branch_addr),
      .issue            (issue),
      .alu_issue_en     (alu_issue_en),
      .mult_issue_en    (mult_issue_en),
      .alu_free         (alu_free),
      .mult_free        (mult_free),
      .cdb              (cdb),
      .debug_addr       (debug_addr),
      .debug_data       (debug_data),
      .quiescent        (quiescent)
   );

   // Both stations see the same issue word and only act on their own enable
   alu_station u_alu_station (
      .clk      (clk),
      .arst_n   (arst_n),
      .issue    (issue),
      .issue_en (alu_issue_en),
      .free     (alu_free),
      .cdb      (cdb),
      .req      (alu_req),
      .gnt      (alu_gnt),
      .result   (alu_result)
   );

   mult_station u_mult_station (
      .clk      (clk),
      .arst_n   (arst_n),
      .issue    (issue),
      .issue_en (mult_issue_en),
      .free     (mult_free),
      .cdb      (cdb),
      .req      (mult_req),
      .gnt      (mult_gnt),
      .result   (mult_result)
   );

   cdb_arbiter u_cdb_arbiter (
      .clk         (clk),
      .arst_n      (arst_n),
      .req_alu     (alu_req),
      .req_mult    (mult_req),
      .gnt_alu     (alu_gnt),
      .gnt_mult    (mult_gnt),
      .result_alu  (alu_result),
      .result_mult (mult_result),
      .cdb         (cdb)
   );

endmodule

// ==== bench/tomasulo_assert.sv ====
`timescale 1ns/1ps

module tomasulo_assert (
   input logic               clk,
   input logic               arst_n,
   input logic [31:0]        ifq_inst,
   input logic               ifq_ren,
   input logic               ifq_branch_valid,
   input logic               alu_issue_en,
   input logic               mult_issue_en,
   input logic               alu_free,
   input logic               mult_free,
   input logic               gnt_alu,
   input logic               gnt_mult,
   input tomasulo_pkg::cdb_t cdb
);
   import isa_pkg::*;

   logic beq_pending;

   // Tracks the dispatch stall from the cycle after a BEQ until its result
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         beq_pending <= 1'b0;
      end else if (ifq_ren && ifq_inst[31:26] == OP_BEQ) begin
         beq_pending <= 1'b1;
      end else if (cdb.valid && cdb.is_branch) begin
         beq_pending <= 1'b0;
      end
   end

   grants_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      !(gnt_alu && gnt_mult)) else $error("both CDB grants high");

   redirect_single: assert property (@(posedge clk) disable iff (!arst_n)
      ifq_branch_valid |=> !ifq_branch_valid) else $error("branch redirect held two cycles");

   alu_issue_free: assert property (@(posedge clk) disable iff (!arst_n)
      alu_issue_en |-> alu_free) else $error("issue to a busy ALU station");

   mult_issue_free: assert property (@(posedge clk) disable iff (!arst_n)
      mult_issue_en |-> mult_free) else $error("issue to a busy multiply station");

   stall_no_read: assert property (@(posedge clk) disable iff (!arst_n)
      beq_pending |-> !ifq_ren) else $error("IFQ read during branch stall");

endmodule

// ==== bench/tb_tomasulo.sv ====
`timescale 1ns/1ps

module tb_tomasulo;
   import isa_pkg::*;
   import tomasulo_pkg::*;

   localparam int NUM_INST    = 200;
   localparam int NUM_NOP     = 8;
   localparam int LEN         = NUM_INST + NUM_NOP;
   localparam int RUN_LIMIT   = 20000;
   localparam int QUIET_LIMIT = 200;

   logic        clk;
   logic        arst_n;
   logic [31:0] ifq_inst;
   logic [31:0] ifq_pc_plus4;
   logic        ifq_empty;
   logic        ifq_ren;
   logic        ifq_branch_valid;
   logic [31:0] ifq_branch_addr;
   logic [4:0]  debug_addr;
   logic [31:0] debug_data;
   logic        quiescent;
   cdb_t        cdb;

   logic [31:0] prog [LEN];
   logic        is_target [LEN];
   logic        exp_redirect [LEN];
   logic [31:0] exp_target [LEN];
   logic [31:0] exp_data [LEN];
   logic [31:0] mrf [32];
   logic        inflight [1 << TAG_W];
   int          tag_src [1 << TAG_W];
   int          trace [$];
   int          trace_pos;
   int          pc;
   int          stall_idx;
   logic        in_stall;
   logic        timed_out;
   int          cycles;
   int          checks;
   int          errors;

   tomasulo_core #(
      .NUM_TAGS (8)
   ) dut0 (
      .clk              (clk),
      .arst_n           (arst_n),
      .ifq_inst         (ifq_inst),
      .ifq_pc_plus4     (ifq_pc_plus4),
      .ifq_empty        (ifq_empty),
      .ifq_ren          (ifq_ren),
      .ifq_branch_valid (ifq_branch_valid),
      .ifq_branch_addr  (ifq_branch_addr),
      .debug_addr       (debug_addr),
      .debug_data       (debug_data),
      .quiescent        (quiescent),
      .cdb              (cdb)
   );

   bind tomasulo_core tomasulo_assert u_assert (
      .clk              (clk),
      .arst_n           (arst_n),
      .ifq_inst         (ifq_inst),
      .ifq_ren          (ifq_ren),
      .ifq_branch_valid (ifq_branch_valid),
      .alu_issue_en     (alu_issue_en),
      .mult_issue_en    (mult_issue_en),
      .alu_free         (alu_free),
      .mult_free        (mult_free),
      .gnt_alu          (alu_gnt),
      .gnt_mult         (mult_gnt),
      .cdb              (cdb)
   );

   always #50 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0d ns %s: expected %0h, got %0h", $time, name, exp, got);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         errors++;
         $display("Error at %0d ns: %s", $time, what);
      end
   endtask

   // Mostly a few low registers, so that dependent chains form often
   function automatic logic [4:0] pick_reg();
      if ($urandom_range(9, 0) < 7) begin
         return 5'($urandom_range(7, 1));
      end
      return 5'($urandom_range(31, 0));
   endfunction

   task automatic build_program();
      int          kind;
      int          off;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      funct_t      fn;
      for (int i = 0; i < LEN; i++) begin
         is_target[i] = 1'b0;
      end
      for (int i = 0; i < NUM_INST; i++) begin
         kind = $urandom_range(11, 0);
         rs   = pick_reg();
         rt   = pick_reg();
         rd   = pick_reg();
         off  = $urandom_range(4, 1);
         // A jump at a redirect target would pulse branch_valid twice in a row
         if (kind == 11 && is_target[i]) begin
            kind = 0;
         end
         fn = kind == 3 ? FN_ADD : kind == 4 ? FN_SUB : kind == 5 ? FN_AND :
              kind == 6 ? FN_OR : kind == 7 ? FN_SLT : FN_MULT;
         if (kind <= 2) begin
            prog[i] = {OP_ADDI, rs, rt, 16'($urandom_range(65535, 0))};
         end else if (kind <= 8) begin
            prog[i] = {OP_RTYPE, rs, rt, rd, 5'd0, fn};
         end else if (kind <= 10) begin
            if ($urandom_range(1, 0) == 1) begin
               rt = rs;
            end
            prog[i] = {OP_BEQ, rs, rt, 16'(off)};
            is_target[i + 1 + off] = 1'b1;
         end else begin
            prog[i] = {OP_J, 26'(off)};
            is_target[i + 1 + off] = 1'b1;
         end
      end
      for (int i = NUM_INST; i < LEN; i++) begin
         prog[i] = {OP_RTYPE, 15'd0, 5'd0, FN_ADD};
      end
   endtask

   // Sequential execution of the program, one instruction at a time
   task automatic run_model();
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      int          idx;
      for (int r = 0; r < 32; r++) begin
         mrf[r] = '0;
      end
      idx = 0;
      while (idx < LEN) begin
         w   = prog[idx];
         a   = mrf[w[25:21]];
         b   = mrf[w[20:16]];
         imm = {{16{w[15]}}, w[15:0]};
         res = '0;
         trace.push_back(idx);
         exp_redirect[idx] = 1'b0;
         exp_target[idx]   = '0;
         if (w[31:26] == OP_ADDI) begin
            res = a + imm;
            if (w[20:16] != 5'd0) begin
               mrf[w[20:16]] = res;
            end
         end else if (w[31:26] == OP_BEQ) begin
            if (a == b) begin
               exp_redirect[idx] = 1'b1;
               exp_target[idx]   = 32'((idx + 1) * 4) + (imm << 2);
            end
         end else if (w[31:26] == OP_J) begin
            exp_redirect[idx] = 1'b1;
            exp_target[idx]   = 32'((idx + 1) * 4) + ({{6{w[25]}}, w[25:0]} << 2);
         end else begin
            case (w[5:0])
               FN_ADD:  res = a + b;
               FN_SUB:  res = a - b;
               FN_AND:  res = a & b;
               FN_OR:   res = a | b;
               FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default: res = a * b;
            endcase
            if (w[15:11] != 5'd0) begin
               mrf[w[15:11]] = res;
            end
         end
         // Value the instruction broadcasts, even when its destination is r0
         exp_data[idx] = res;
         idx = exp_redirect[idx] ? int'(exp_target[idx] >> 2) : idx + 1;
      end
   endtask

   task automatic drive_ifq();
      ifq_empty    = pc >= LEN;
      ifq_inst     = pc < LEN ? prog[pc] : 32'd0;
      ifq_pc_plus4 = 32'(pc * 4 + 4);
   endtask

   // Samples at the falling edge, where all DUT outputs have settled
   task automatic monitor_cycle();
      logic        consume;
      logic        was_stall;
      logic        bv_exp;
      logic [31:0] addr_exp;
      logic [31:0] w;
      int          next_pc;
      int          src;
      consume   = ifq_ren && !ifq_empty;
      was_stall = in_stall;
      bv_exp    = 1'b0;
      addr_exp  = '0;
      next_pc   = pc;
      if (cdb.valid) begin
         check_true(inflight[cdb.tag], "CDB carried a tag that was not outstanding");
         inflight[cdb.tag] = 1'b0;
         src = tag_src[cdb.tag];
         check_value("cdb.is_branch", 32'(cdb.is_branch),
                     32'(prog[src][31:26] == OP_BEQ));
         if (prog[src][31:26] != OP_BEQ) begin
            check_value("cdb.data", cdb.data, exp_data[src]);
         end
         if (cdb.is_branch) begin
            check_true(in_stall, "branch result on the CDB with no BEQ pending");
            if (in_stall && exp_redirect[stall_idx]) begin
               bv_exp   = 1'b1;
               addr_exp = exp_target[stall_idx];
            end
            in_stall = 1'b0;
         end
      end
      if (consume) begin
         check_true(!was_stall, "instruction consumed before the BEQ result");
         check_true(trace_pos < trace.size(), "more instructions consumed than executed");
         if (trace_pos < trace.size()) begin
            check_value("consumed pc", 32'(pc * 4), 32'(trace[trace_pos] * 4));
         end
         trace_pos++;
         w       = prog[pc];
         next_pc = pc + 1;
         if (w[31:26] == OP_J) begin
            bv_exp   = 1'b1;
            addr_exp = exp_target[pc];
         end else begin
            check_true(!inflight[dut0.issue.dest], "issued tag is already outstanding");
            inflight[dut0.issue.dest] = 1'b1;
            tag_src[dut0.issue.dest]  = pc;
         end
         if (w[31:26] == OP_BEQ) begin
            in_stall  = 1'b1;
            stall_idx = pc;
         end
      end
      check_value("ifq_branch_valid", 32'(ifq_branch_valid), 32'(bv_exp));
      if (bv_exp) begin
         check_value("ifq_branch_addr", ifq_branch_addr, addr_exp);
      end
      if (ifq_branch_valid) begin
         next_pc = int'(ifq_branch_addr >> 2);
      end
      pc = next_pc > LEN ? LEN : next_pc;
   endtask

   task automatic run_cycle();
      @(negedge clk);
      monitor_cycle();
      @(posedge clk);
      #1;
      drive_ifq();
   endtask

   initial begin
      clk          = 1'b0;
      arst_n       = 1'b0;
      ifq_inst     = '0;
      ifq_pc_plus4 = '0;
      ifq_empty    = 1'b1;
      debug_addr   = '0;
      checks       = 0;
      errors       = 0;
      trace_pos    = 0;
      stall_idx    = 0;
      in_stall     = 1'b0;
      timed_out    = 1'b0;
      pc           = LEN;
      for (int t = 0; t < (1 << TAG_W); t++) begin
         inflight[t] = 1'b0;
         tag_src[t]  = 0;
      end
      void'($urandom(7));
      build_program();
      run_model();

      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // Idle core with an empty queue
      repeat (4) begin
         @(negedge clk);
         check_value("ifq_ren", 32'(ifq_ren), 32'd0);
         check_value("ifq_branch_valid", 32'(ifq_branch_valid), 32'd0);
         check_value("cdb.valid", 32'(cdb.valid), 32'd0);
         check_value("quiescent", 32'(quiescent), 32'd1);
      end
      @(posedge clk);
      #1;
      pc = 0;
      drive_ifq();

      cycles = 0;
      while (!(pc >= LEN && !in_stall) && cycles < RUN_LIMIT) begin
         run_cycle();
         cycles++;
      end
      if (cycles >= RUN_LIMIT) begin
         timed_out = 1'b1;
         errors++;
         $display("Timeout: the program did not finish within %0d cycles", RUN_LIMIT);
      end

      if (!timed_out) begin
         cycles = 0;
         while (!quiescent && cycles < QUIET_LIMIT) begin
            run_cycle();
            cycles++;
         end
         if (cycles >= QUIET_LIMIT) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: the core never went quiescent after the program");
         end
      end

      if (!timed_out) begin
         check_value("consumed count", 32'(trace_pos), 32'(trace.size()));
         for (int t = 0; t < (1 << TAG_W); t++) begin
            check_true(!inflight[t], $sformatf("tag %0d was issued but never broadcast", t));
         end
         for (int r = 1; r < 32; r++) begin
            debug_addr = 5'(r);
            @(negedge clk);
            check_value($sformatf("debug_data[r%0d]", r), debug_data, mrf[r]);
            @(posedge clk);
            #1;
         end
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
common/isa_pkg.sv
common/tomasulo_pkg.sv
hw/dispatch/reg_status_file.sv
hw/dispatch/tag_fifo.sv
hw/dispatch/dispatch.sv
hw/alu_station.sv
hw/mult_station.sv
hw/cdb_arbiter.sv
hw/tomasulo_core.sv
bench/tomasulo_assert.sv
bench/tb_tomasulo.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_tomasulo -f sources.f -o sim_tb > sim.log 2>&1 &&
   ./obj_dir/sim_tb >> sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || grep -q "Result: PASSED" sim.log || exit 1
